/* logic/decode_pkg.sv */
package decode_pkg;

	// datapath widths
	localparam int DATA_W   = 32;
	localparam int REG_W    = 5;
	localparam int OPCODE_W = 6;
	localparam int FUNCT_W  = 6;
	localparam int PC_W     = 7;
	localparam int IMM_W    = 16;
	localparam int TARGET_W = 26;

	// execute side has four slots
	localparam int CREDIT_DEPTH = 4;
	localparam int CREDIT_W     = 3;

	// opcodes
	localparam logic [OPCODE_W-1:0] OP_RTYPE = 6'd0;
	localparam logic [OPCODE_W-1:0] OP_J     = 6'd2;
	localparam logic [OPCODE_W-1:0] OP_JAL   = 6'd3;
	localparam logic [OPCODE_W-1:0] OP_BEQ   = 6'd4;
	localparam logic [OPCODE_W-1:0] OP_BNE   = 6'd5;
	localparam logic [OPCODE_W-1:0] OP_ADDI  = 6'd8;
	localparam logic [OPCODE_W-1:0] OP_ANDI  = 6'd12;
	localparam logic [OPCODE_W-1:0] OP_ORI   = 6'd13;
	localparam logic [OPCODE_W-1:0] OP_LW    = 6'd35;
	localparam logic [OPCODE_W-1:0] OP_SW    = 6'd43;
	localparam logic [OPCODE_W-1:0] OP_HALT  = 6'd63;

	// destination select, rt is the zero code so idle control is all low
	localparam logic [1:0] REG_DST_RT = 2'd0;
	localparam logic [1:0] REG_DST_RD = 2'd1;
	localparam logic [1:0] REG_DST_RA = 2'd2;

	// link register for jal
	localparam logic [REG_W-1:0] REG_RA = 5'd31;

	// decode latch states
	localparam logic [1:0] ST_EMPTY  = 2'd0;
	localparam logic [1:0] ST_FULL   = 2'd1;
	localparam logic [1:0] ST_HALTED = 2'd2;

	// one instruction word, three field layouts
	typedef union packed {
		struct packed {
			logic [OPCODE_W-1:0] opcode;
			logic [REG_W-1:0]    rs;
			logic [REG_W-1:0]    rt;
			logic [REG_W-1:0]    rd;
			logic [REG_W-1:0]    shamt;
			logic [FUNCT_W-1:0]  funct;
		} r;
		struct packed {
			logic [OPCODE_W-1:0] opcode;
			logic [REG_W-1:0]    rs;
			logic [REG_W-1:0]    rt;
			logic [IMM_W-1:0]    imm;
		} i;
		struct packed {
			logic [OPCODE_W-1:0] opcode;
			logic [TARGET_W-1:0] target;
		} j;
	} instr_u;

endpackage

/* logic/reg_bank.sv */
`timescale 1ns/100ps

module reg_bank
	import decode_pkg::*;
(
	input  logic              clock_i,
	input  logic              rst_i,
	input  logic              we_i,
	input  logic [REG_W-1:0]  wr_addr_i,
	input  logic [DATA_W-1:0] wr_data_i,
	input  logic [REG_W-1:0]  rd_addr_a_i,
	input  logic [REG_W-1:0]  rd_addr_b_i,
	output logic [DATA_W-1:0] rd_data_a_o,
	output logic [DATA_W-1:0] rd_data_b_o
);

	logic [DATA_W-1:0] regs [0:(1<<REG_W)-1];

	// one read port, write bypass first
	function automatic logic [DATA_W-1:0] read_port(input logic [REG_W-1:0] addr);
		logic [DATA_W-1:0] val;
		if (addr == '0)
			val = '0;
		else if (we_i && (wr_addr_i == addr))
			val = wr_data_i;
		else
			val = regs[addr];
		return val;
	endfunction

	// whole bank clears on reset
	always_ff @(posedge clock_i) begin
		if (rst_i) begin
			for (int k = 0; k < (1<<REG_W); k++)
				regs[k] <= '0;
		end else if (we_i && (wr_addr_i != '0)) begin
			// r0 never written
			regs[wr_addr_i] <= wr_data_i;
		end
	end

	// port a, debug address may be muxed in above
	always_comb begin
		rd_data_a_o = read_port(rd_addr_a_i);
	end

	// port b, always rt
	always_comb begin
		rd_data_b_o = read_port(rd_addr_b_i);
	end

endmodule

/* logic/instr_decoder.sv */
`timescale 1ns/100ps

module instr_decoder
	import decode_pkg::*;
(
	input  instr_u              instr_i,
	input  logic [PC_W-1:0]     pc_i,
	output logic [REG_W-1:0]    rs_o,
	output logic [REG_W-1:0]    rt_o,
	output logic [REG_W-1:0]    dest_o,
	output logic [OPCODE_W-1:0] opcode_o,
	output logic [FUNCT_W-1:0]  funct_o,
	output logic [REG_W-1:0]    shamt_o,
	output logic [DATA_W-1:0]   imm_ext_o,
	output logic                reg_write_o,
	output logic                mem_read_o,
	output logic                mem_write_o,
	output logic                mem_to_reg_o,
	output logic                alu_src_imm_o,
	output logic [1:0]          reg_dst_o,
	output logic                is_branch_o,
	output logic                is_bne_o,
	output logic                is_jump_o,
	output logic                is_halt_o,
	output logic [PC_W-1:0]     jump_target_o
);

	logic [REG_W-1:0] rd_f;
	logic [IMM_W-1:0] imm_f;

	// opcode sits in the same bits in every view
	assign opcode_o = instr_i.r.opcode;

	always_comb begin
		// idle values, unknown opcode keeps all control low
		rs_o          = '0;
		rt_o          = '0;
		rd_f          = '0;
		shamt_o       = '0;
		funct_o       = '0;
		imm_f         = '0;
		reg_write_o   = 1'b0;
		mem_read_o    = 1'b0;
		mem_write_o   = 1'b0;
		mem_to_reg_o  = 1'b0;
		alu_src_imm_o = 1'b0;
		reg_dst_o     = REG_DST_RT;
		is_branch_o   = 1'b0;
		is_bne_o      = 1'b0;
		is_jump_o     = 1'b0;
		is_halt_o     = 1'b0;
		case (opcode_o)
			OP_RTYPE: begin
				rs_o        = instr_i.r.rs;
				rt_o        = instr_i.r.rt;
				rd_f        = instr_i.r.rd;
				shamt_o     = instr_i.r.shamt;
				funct_o     = instr_i.r.funct;
				reg_write_o = 1'b1;
				reg_dst_o   = REG_DST_RD;
			end
			OP_ADDI, OP_ANDI, OP_ORI, OP_LW: begin
				rs_o          = instr_i.i.rs;
				rt_o          = instr_i.i.rt;
				imm_f         = instr_i.i.imm;
				reg_write_o   = 1'b1;
				alu_src_imm_o = 1'b1;
				// load also goes through memory
				mem_read_o    = (opcode_o == OP_LW);
				mem_to_reg_o  = (opcode_o == OP_LW);
			end
			OP_SW: begin
				rs_o          = instr_i.i.rs;
				rt_o          = instr_i.i.rt;
				imm_f         = instr_i.i.imm;
				mem_write_o   = 1'b1;
				alu_src_imm_o = 1'b1;
			end
			OP_BEQ, OP_BNE: begin
				rs_o        = instr_i.i.rs;
				rt_o        = instr_i.i.rt;
				imm_f       = instr_i.i.imm;
				is_branch_o = 1'b1;
				is_bne_o    = (opcode_o == OP_BNE);
			end
			OP_J: begin
				is_jump_o = 1'b1;
			end
			OP_JAL: begin
				is_jump_o   = 1'b1;
				reg_write_o = 1'b1;
				reg_dst_o   = REG_DST_RA;
			end
			OP_HALT: begin
				is_halt_o = 1'b1;
			end
			default: begin
			end
		endcase
	end

	// sign extend to full width
	assign imm_ext_o = {{(DATA_W-IMM_W){imm_f[IMM_W-1]}}, imm_f};

	// low bits of the target field, pc space is only 7 bits wide
	assign jump_target_o = instr_i.j.target[PC_W-1:0];

	// write register picked by reg_dst
	always_comb begin
		case (reg_dst_o)
			REG_DST_RD: dest_o = rd_f;
			REG_DST_RA: dest_o = REG_RA;
			default:    dest_o = rt_o;
		endcase
	end

endmodule

/* logic/branch_resolve.sv */
`timescale 1ns/100ps

module branch_resolve
	import decode_pkg::*;
(
	input  logic [PC_W-1:0]   pc_i,
	input  logic [DATA_W-1:0] imm_ext_i,
	input  logic [DATA_W-1:0] data_a_i,
	input  logic [DATA_W-1:0] data_b_i,
	input  logic [DATA_W-1:0] alu_result_i,
	input  logic              fwd_a_i,
	input  logic              fwd_b_i,
	input  logic              is_branch_i,
	input  logic              is_bne_i,
	output logic              branch_taken_o,
	output logic [PC_W-1:0]   branch_target_o
);

	logic [DATA_W-1:0] cmp_a;
	logic [DATA_W-1:0] cmp_b;
	logic              equal;
	logic [PC_W-1:0]   pc_next;

	// alu result bypasses the bank for the compare only
	assign cmp_a = fwd_a_i ? alu_result_i : data_a_i;
	assign cmp_b = fwd_b_i ? alu_result_i : data_b_i;

	assign equal = (cmp_a == cmp_b);

	// beq wants equal, bne wants different
	assign branch_taken_o = is_branch_i && (is_bne_i ? !equal : equal);

	// word addressed pc, offset from the next instruction
	assign pc_next         = pc_i + PC_W'(1);
	assign branch_target_o = pc_next + imm_ext_i[PC_W-1:0];

endmodule

/* logic/credit_counter.sv */
`timescale 1ns/100ps

module credit_counter
	import decode_pkg::*;
(
	input  logic clock_i,
	input  logic rst_i,
	input  logic issue_i,
	input  logic credit_return_i,
	output logic credit_avail_o
);

	logic [CREDIT_W-1:0] count;

	// free slots in execute
	always_ff @(posedge clock_i) begin
		if (rst_i) begin
			count <= CREDIT_W'(CREDIT_DEPTH);
		end else begin
			case ({issue_i, credit_return_i})
				2'b10: begin
					// issue only ever fires with a credit free
					if (count != '0)
						count <= count - CREDIT_W'(1);
				end
				2'b01: begin
					// stray return saturates at depth
					if (count != CREDIT_W'(CREDIT_DEPTH))
						count <= count + CREDIT_W'(1);
				end
				default: begin
					// none, or both in the same cycle
				end
			endcase
		end
	end

	assign credit_avail_o = (count != '0);

endmodule

/* logic/issue_fsm.sv */
`timescale 1ns/100ps

module issue_fsm
	import decode_pkg::*;
(
	input  logic              clock_i,
	input  logic              rst_i,
	input  logic              instr_valid_i,
	input  logic [DATA_W-1:0] instr_i,
	input  logic [PC_W-1:0]   pc_i,
	input  logic              credit_avail_i,
	input  logic              is_halt_i,
	output logic              instr_ready_o,
	output logic              issue_o,
	output logic [DATA_W-1:0] latch_instr_o,
	output logic [PC_W-1:0]   latch_pc_o,
	output logic              halted_o
);

	logic [1:0] state;
	logic [1:0] state_nxt;
	logic       accept;

	// halt sitting in the latch is never issued
	assign issue_o = (state == ST_FULL) && credit_avail_i && !is_halt_i;

	// empty latch, or one that drains this cycle
	assign instr_ready_o = (state == ST_EMPTY) || issue_o;
	assign accept        = instr_valid_i && instr_ready_o;
	assign halted_o      = (state == ST_HALTED);

	always_comb begin
		state_nxt = state;
		case (state)
			ST_EMPTY: begin
				if (accept)
					state_nxt = ST_FULL;
			end
			ST_FULL: begin
				if (is_halt_i)
					state_nxt = ST_HALTED;
				else if (issue_o && !accept)
					state_nxt = ST_EMPTY;
			end
			ST_HALTED: begin
				// held until reset
			end
			default: state_nxt = ST_EMPTY;
		endcase
	end

	always_ff @(posedge clock_i) begin
		if (rst_i)
			state <= ST_EMPTY;
		else
			state <= state_nxt;
	end

	// decode latch
	always_ff @(posedge clock_i) begin
		if (accept) begin
			latch_instr_o <= instr_i;
			latch_pc_o    <= pc_i;
		end else if ((state == ST_FULL) && is_halt_i) begin
			// drop the halt word, zero decodes as a harmless r-type
			latch_instr_o <= '0;
		end
	end

endmodule

/* logic/decode_top.sv */
`timescale 1ns/100ps

module decode_top
	import decode_pkg::*;
(
	input  logic                clock_i,
	input  logic                rst_i,
	input  logic                instr_valid_i,
	input  logic [DATA_W-1:0]   instr_i,
	input  logic [PC_W-1:0]     pc_i,
	input  logic                credit_return_i,
	input  logic                reg_write_i,
	input  logic [REG_W-1:0]    wr_addr_i,
	input  logic [DATA_W-1:0]   wr_data_i,
	input  logic [DATA_W-1:0]   alu_result_i,
	input  logic                fwd_a_i,
	input  logic                fwd_b_i,
	input  logic                dbg_sel_i,
	input  logic [REG_W-1:0]    dbg_addr_i,
	output logic                instr_ready_o,
	output logic                issue_valid_o,
	output logic                halted_o,
	output logic [REG_W-1:0]    rs_o,
	output logic [REG_W-1:0]    rt_o,
	output logic [REG_W-1:0]    dest_o,
	output logic [OPCODE_W-1:0] opcode_o,
	output logic [FUNCT_W-1:0]  funct_o,
	output logic [REG_W-1:0]    shamt_o,
	output logic [DATA_W-1:0]   imm_ext_o,
	output logic                reg_write_o,
	output logic                mem_read_o,
	output logic                mem_write_o,
	output logic                mem_to_reg_o,
	output logic                alu_src_imm_o,
	output logic [1:0]          reg_dst_o,
	output logic                is_branch_o,
	output logic                is_bne_o,
	output logic                is_jump_o,
	output logic [PC_W-1:0]     jump_target_o,
	output logic [DATA_W-1:0]   data_a_o,
	output logic [DATA_W-1:0]   data_b_o,
	output logic                branch_taken_o,
	output logic [PC_W-1:0]     branch_target_o
);

	logic              credit_avail;
	logic              is_halt;
	logic [DATA_W-1:0] latch_instr;
	logic [PC_W-1:0]   latch_pc;
	logic [REG_W-1:0]  rd_addr_a;

	// latch, handshake, halt
	issue_fsm issue_fsm_inst (
		.clock_i        (clock_i),
		.rst_i          (rst_i),
		.instr_valid_i  (instr_valid_i),
		.instr_i        (instr_i),
		.pc_i           (pc_i),
		.credit_avail_i (credit_avail),
		.is_halt_i      (is_halt),
		.instr_ready_o  (instr_ready_o),
		.issue_o        (issue_valid_o),
		.latch_instr_o  (latch_instr),
		.latch_pc_o     (latch_pc),
		.halted_o       (halted_o)
	);

	credit_counter credit_counter_inst (
		.clock_i         (clock_i),
		.rst_i           (rst_i),
		.issue_i         (issue_valid_o),
		.credit_return_i (credit_return_i),
		.credit_avail_o  (credit_avail)
	);

	// decodes whatever sits in the latch
	instr_decoder instr_decoder_inst (
		.instr_i       (latch_instr),
		.pc_i          (latch_pc),
		.rs_o          (rs_o),
		.rt_o          (rt_o),
		.dest_o        (dest_o),
		.opcode_o      (opcode_o),
		.funct_o       (funct_o),
		.shamt_o       (shamt_o),
		.imm_ext_o     (imm_ext_o),
		.reg_write_o   (reg_write_o),
		.mem_read_o    (mem_read_o),
		.mem_write_o   (mem_write_o),
		.mem_to_reg_o  (mem_to_reg_o),
		.alu_src_imm_o (alu_src_imm_o),
		.reg_dst_o     (reg_dst_o),
		.is_branch_o   (is_branch_o),
		.is_bne_o      (is_bne_o),
		.is_jump_o     (is_jump_o),
		.is_halt_o     (is_halt),
		.jump_target_o (jump_target_o)
	);

	// debug address steals port a
	assign rd_addr_a = dbg_sel_i ? dbg_addr_i : rs_o;

	reg_bank reg_bank_inst (
		.clock_i     (clock_i),
		.rst_i       (rst_i),
		.we_i        (reg_write_i),
		.wr_addr_i   (wr_addr_i),
		.wr_data_i   (wr_data_i),
		.rd_addr_a_i (rd_addr_a),
		.rd_addr_b_i (rt_o),
		.rd_data_a_o (data_a_o),
		.rd_data_b_o (data_b_o)
	);

	branch_resolve branch_resolve_inst (
		.pc_i            (latch_pc),
		.imm_ext_i       (imm_ext_o),
		.data_a_i        (data_a_o),
		.data_b_i        (data_b_o),
		.alu_result_i    (alu_result_i),
		.fwd_a_i         (fwd_a_i),
		.fwd_b_i         (fwd_b_i),
		.is_branch_i     (is_branch_o),
		.is_bne_i        (is_bne_o),
		.branch_taken_o  (branch_taken_o),
		.branch_target_o (branch_target_o)
	);

endmodule

/* tb/tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen (
	input  logic rst_req_i,
	output logic clock_o,
	output logic rst_o
);

	localparam int HALF_PERIOD  = 50;
	localparam int RESET_CYCLES = 10;
	localparam int OUT_DLY      = 10;

	int hold_cnt;

	// 100 ns period, first rising edge at 50 ns
	initial begin
		clock_o = 1'b0;
		forever #HALF_PERIOD clock_o = ~clock_o;
	end

	// reset held for ten rising edges at power up and again on request
	initial begin
		rst_o    = 1'b1;
		hold_cnt = RESET_CYCLES;
		forever begin
			@(posedge clock_o);
			if (rst_req_i)
				hold_cnt = RESET_CYCLES;
			else if (hold_cnt > 0)
				hold_cnt = hold_cnt - 1;
			// change away from the edge like every other input
			#OUT_DLY;
			rst_o = (hold_cnt != 0);
		end
	end

endmodule

/* tb/decode_tb.sv */
`timescale 1ns/100ps

module decode_tb
	import decode_pkg::*;
();

	localparam int DRIVE_DLY  = 10;
	localparam int WAIT_LIMIT = 50;
	// what a bounded wait looks at
	localparam int SIG_READY  = 0;
	localparam int SIG_ISSUE  = 1;
	localparam int SIG_RUN    = 2;

	logic              clock;
	logic              rst;
	logic              rst_req;
	logic              instr_valid;
	logic [DATA_W-1:0] instr;
	logic [PC_W-1:0]   pc;
	logic              credit_return;
	logic              bank_we;
	logic [REG_W-1:0]  wr_addr;
	logic [DATA_W-1:0] wr_data;
	logic [DATA_W-1:0] alu_result;
	logic              fwd_a;
	logic              fwd_b;
	logic              dbg_sel;
	logic [REG_W-1:0]  dbg_addr;

	logic                instr_ready;
	logic                issue_valid;
	logic                halted;
	logic [REG_W-1:0]    rs;
	logic [REG_W-1:0]    rt;
	logic [REG_W-1:0]    dest;
	logic [OPCODE_W-1:0] opcode;
	logic [FUNCT_W-1:0]  funct;
	logic [REG_W-1:0]    shamt;
	logic [DATA_W-1:0]   imm_ext;
	logic                reg_write;
	logic                mem_read;
	logic                mem_write;
	logic                mem_to_reg;
	logic                alu_src_imm;
	logic [1:0]          reg_dst;
	logic                is_branch;
	logic                is_bne;
	logic                is_jump;
	logic [PC_W-1:0]     jump_target;
	logic [DATA_W-1:0]   data_a;
	logic [DATA_W-1:0]   data_b;
	logic                branch_taken;
	logic [PC_W-1:0]     branch_target;

	logic [15:0]       lfsr_q;
	logic [DATA_W-1:0] reg_model [0:(1<<REG_W)-1];
	int                err_cnt;
	int                test_err_base;
	int                tests_run;
	int                tests_failed;
	string             cur_test;

	tb_clock_gen clock_gen_inst (
		.rst_req_i (rst_req),
		.clock_o   (clock),
		.rst_o     (rst)
	);

	decode_top decode_top_inst (
		.clock_i         (clock),
		.rst_i           (rst),
		.instr_valid_i   (instr_valid),
		.instr_i         (instr),
		.pc_i            (pc),
		.credit_return_i (credit_return),
		.reg_write_i     (bank_we),
		.wr_addr_i       (wr_addr),
		.wr_data_i       (wr_data),
		.alu_result_i    (alu_result),
		.fwd_a_i         (fwd_a),
		.fwd_b_i         (fwd_b),
		.dbg_sel_i       (dbg_sel),
		.dbg_addr_i      (dbg_addr),
		.instr_ready_o   (instr_ready),
		.issue_valid_o   (issue_valid),
		.halted_o        (halted),
		.rs_o            (rs),
		.rt_o            (rt),
		.dest_o          (dest),
		.opcode_o        (opcode),
		.funct_o         (funct),
		.shamt_o         (shamt),
		.imm_ext_o       (imm_ext),
		.reg_write_o     (reg_write),
		.mem_read_o      (mem_read),
		.mem_write_o     (mem_write),
		.mem_to_reg_o    (mem_to_reg),
		.alu_src_imm_o   (alu_src_imm),
		.reg_dst_o       (reg_dst),
		.is_branch_o     (is_branch),
		.is_bne_o        (is_bne),
		.is_jump_o       (is_jump),
		.jump_target_o   (jump_target),
		.data_a_o        (data_a),
		.data_b_o        (data_b),
		.branch_taken_o  (branch_taken),
		.branch_target_o (branch_target)
	);

	// x^16 + x^14 + x^13 + x^11 + 1, one step per bit
	function automatic logic lfsr_bit();
		logic fb;
		fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
		lfsr_q = {lfsr_q[14:0], fb};
		return fb;
	endfunction

	function automatic logic [DATA_W-1:0] rand_word();
		logic [DATA_W-1:0] w;
		w = '0;
		for (int b = 0; b < DATA_W; b++)
			w = {w[DATA_W-2:0], lfsr_bit()};
		return w;
	endfunction

	// instruction builders, one per field layout
	function automatic instr_u make_r(input logic [REG_W-1:0] rs_f, input logic [REG_W-1:0] rt_f,
			input logic [REG_W-1:0] rd_f, input logic [REG_W-1:0] sh_f,
			input logic [FUNCT_W-1:0] fn_f);
		instr_u w;
		w          = '0;
		w.r.opcode = OP_RTYPE;
		w.r.rs     = rs_f;
		w.r.rt     = rt_f;
		w.r.rd     = rd_f;
		w.r.shamt  = sh_f;
		w.r.funct  = fn_f;
		return w;
	endfunction

	function automatic instr_u make_i(input logic [OPCODE_W-1:0] op, input logic [REG_W-1:0] rs_f,
			input logic [REG_W-1:0] rt_f, input logic [15:0] imm_f);
		instr_u w;
		w          = '0;
		w.i.opcode = op;
		w.i.rs     = rs_f;
		w.i.rt     = rt_f;
		w.i.imm    = imm_f;
		return w;
	endfunction

	function automatic instr_u make_j(input logic [OPCODE_W-1:0] op, input logic [25:0] tgt);
		instr_u w;
		w          = '0;
		w.j.opcode = op;
		w.j.target = tgt;
		return w;
	endfunction

	task automatic cmp_data(input string what, input logic [DATA_W-1:0] exp,
			input logic [DATA_W-1:0] act);
		if (exp !== act) begin
			err_cnt++;
			$display("[ERROR] %s %s: expected %h, actual %h", cur_test, what, exp, act);
		end
	endtask

	task automatic cmp_reg(input string what, input logic [REG_W-1:0] exp,
			input logic [REG_W-1:0] act);
		if (exp !== act) begin
			err_cnt++;
			$display("[ERROR] %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
		end
	endtask

	task automatic cmp_ctrl(input string what, input logic exp, input logic act);
		if (exp !== act) begin
			err_cnt++;
			$display("[ERROR] %s %s: expected %b, actual %b", cur_test, what, exp, act);
		end
	endtask

	task automatic cmp_pc(input string what, input logic [PC_W-1:0] exp,
			input logic [PC_W-1:0] act);
		if (exp !== act) begin
			err_cnt++;
			$display("[ERROR] %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
		end
	endtask

	task automatic begin_test(input string name);
		cur_test      = name;
		test_err_base = err_cnt;
		tests_run++;
	endtask

	task automatic finish_test();
		if (err_cnt == test_err_base) begin
			$display("%s: ok", cur_test);
		end else begin
			tests_failed++;
			$display("%s: FAIL (%0d errors)", cur_test, err_cnt - test_err_base);
		end
	endtask

	function automatic logic probe(input int sel);
		case (sel)
			SIG_READY: return instr_ready;
			SIG_ISSUE: return issue_valid;
			default:   return !rst;
		endcase
	endfunction

	// sampled at the falling edge, returns there
	task automatic wait_until(input int sel, input string what, output bit ok);
		ok = 1'b0;
		for (int n = 0; n < WAIT_LIMIT; n++) begin
			if (!ok) begin
				@(negedge clock);
				ok = probe(sel);
			end
		end
		if (!ok) begin
			err_cnt++;
			$display("timeout in %s: %s never came within %0d cycles", cur_test, what, WAIT_LIMIT);
		end
	endtask

	task automatic send_instr(input instr_u ins, input logic [PC_W-1:0] pc_val, output bit ok);
		instr_valid = 1'b1;
		instr       = ins;
		pc          = pc_val;
		wait_until(SIG_READY, "instr_ready_o", ok);
		// transfer on this edge
		@(posedge clock);
		#DRIVE_DLY;
		instr_valid = 1'b0;
	endtask

	// returns at the falling edge of the issue cycle
	task automatic issue_one(input instr_u ins, input logic [PC_W-1:0] pc_val, output bit ok);
		send_instr(ins, pc_val, ok);
		if (ok)
			wait_until(SIG_ISSUE, "issue_valid_o", ok);
	endtask

	// one pulse per cycle, n cycles back to back
	task automatic give_credits(input int n);
		@(posedge clock);
		#DRIVE_DLY;
		credit_return = 1'b1;
		repeat (n) begin
			@(posedge clock);
			#DRIVE_DLY;
		end
		credit_return = 1'b0;
	endtask

	task automatic expect_ctrl(input logic rw, input logic mr, input logic mw, input logic alu,
			input logic br, input logic jmp);
		cmp_ctrl("reg_write", rw, reg_write);
		cmp_ctrl("mem_read", mr, mem_read);
		cmp_ctrl("mem_write", mw, mem_write);
		// loads are the only memory to register path
		cmp_ctrl("mem_to_reg", mr, mem_to_reg);
		cmp_ctrl("alu_src_imm", alu, alu_src_imm);
		cmp_ctrl("is_branch", br, is_branch);
		cmp_ctrl("is_jump", jmp, is_jump);
	endtask

	task automatic reg_bank_readback();
		logic [DATA_W-1:0] val;
		begin_test("reg_bank");
		dbg_sel = 1'b1;
		for (int r = 0; r < 9; r++) begin
			val      = rand_word();
			bank_we  = 1'b1;
			wr_addr  = REG_W'(r);
			wr_data  = val;
			dbg_addr = REG_W'(r);
			// r0 stays zero whatever is written
			if (r != 0)
				reg_model[r] = val;
			@(negedge clock);
			cmp_data($sformatf("write-through r%0d", r), reg_model[r], data_a);
			@(posedge clock);
			#DRIVE_DLY;
		end
		bank_we = 1'b0;
		for (int r = 0; r < 9; r++) begin
			dbg_addr = REG_W'(r);
			@(negedge clock);
			cmp_data($sformatf("readback r%0d", r), reg_model[r], data_a);
			@(posedge clock);
			#DRIVE_DLY;
		end
		dbg_sel = 1'b0;
		finish_test();
	endtask

	task automatic rtype_decode();
		bit ok;
		begin_test("rtype_decode");
		issue_one(make_r(5'd3, 5'd5, 5'd9, 5'd7, 6'h20), 7'd10, ok);
		if (ok) begin
			cmp_data("opcode", DATA_W'(OP_RTYPE), DATA_W'(opcode));
			cmp_reg("rs", 5'd3, rs);
			cmp_reg("rt", 5'd5, rt);
			cmp_reg("dest", 5'd9, dest);
			cmp_data("reg_dst", DATA_W'(REG_DST_RD), DATA_W'(reg_dst));
			cmp_reg("shamt", 5'd7, shamt);
			cmp_data("funct", DATA_W'(6'h20), DATA_W'(funct));
			expect_ctrl(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
			cmp_data("data_a", reg_model[3], data_a);
			cmp_data("data_b", reg_model[5], data_b);
		end
		give_credits(1);
		finish_test();
	endtask

	task automatic check_itype(input logic [OPCODE_W-1:0] op, input logic [15:0] imm,
			input logic [DATA_W-1:0] exp_ext, input logic rw, input logic mr, input logic mw);
		bit ok;
		issue_one(make_i(op, 5'd2, 5'd4, imm), 7'd30, ok);
		if (ok) begin
			cmp_data("opcode", DATA_W'(op), DATA_W'(opcode));
			cmp_reg("rs", 5'd2, rs);
			cmp_reg("rt", 5'd4, rt);
			cmp_data("imm_ext", exp_ext, imm_ext);
			expect_ctrl(rw, mr, mw, 1'b1, 1'b0, 1'b0);
			// immediate forms write rt
			if (rw) begin
				cmp_reg("dest", 5'd4, dest);
				cmp_data("reg_dst", DATA_W'(REG_DST_RT), DATA_W'(reg_dst));
			end
			cmp_data("data_a", reg_model[2], data_a);
			cmp_data("data_b", reg_model[4], data_b);
		end
		give_credits(1);
	endtask

	task automatic itype_decode();
		begin_test("itype_decode");
		check_itype(OP_ADDI, 16'hFFFB, 32'hFFFF_FFFB, 1'b1, 1'b0, 1'b0);
		check_itype(OP_LW, 16'h0040, 32'h0000_0040, 1'b1, 1'b1, 1'b0);
		check_itype(OP_SW, 16'h8000, 32'hFFFF_8000, 1'b0, 1'b0, 1'b1);
		finish_test();
	endtask

	// rs = r3 and rt = r5 from the bank unless forwarded
	task automatic check_branch(input logic [OPCODE_W-1:0] op, input logic fa, input logic fb,
			input logic [DATA_W-1:0] alu_val, input logic [PC_W-1:0] pc_val,
			input logic [15:0] imm, input logic exp_taken, input logic [PC_W-1:0] exp_tgt);
		bit ok;
		fwd_a      = fa;
		fwd_b      = fb;
		alu_result = alu_val;
		issue_one(make_i(op, 5'd3, 5'd5, imm), pc_val, ok);
		if (ok) begin
			cmp_data("opcode", DATA_W'(op), DATA_W'(opcode));
			cmp_ctrl("is_branch", 1'b1, is_branch);
			cmp_ctrl("is_bne", op == OP_BNE, is_bne);
			cmp_ctrl("branch_taken", exp_taken, branch_taken);
			cmp_pc("branch_target", exp_tgt, branch_target);
		end
		give_credits(1);
		fwd_a = 1'b0;
		fwd_b = 1'b0;
	endtask

	task automatic branch_jump();
		bit ok;
		begin_test("branch_jump");
		check_branch(OP_BEQ, 1'b0, 1'b0, '0, 7'd20, 16'hFFFD, reg_model[3] == reg_model[5], 7'd18);
		check_branch(OP_BEQ, 1'b1, 1'b0, reg_model[5], 7'd20, 16'hFFFD, 1'b1, 7'd18);
		check_branch(OP_BNE, 1'b0, 1'b1, reg_model[3], 7'd100, 16'd40, 1'b0, 7'd13);
		check_branch(OP_BNE, 1'b1, 1'b0, ~reg_model[5], 7'd100, 16'd40, 1'b1, 7'd13);
		// next pc wraps past the top of the 7-bit range
		check_branch(OP_BNE, 1'b0, 1'b0, '0, 7'd127, 16'd0, reg_model[3] != reg_model[5], 7'd0);
		issue_one(make_j(OP_J, 26'h0000ABC), 7'd60, ok);
		if (ok) begin
			cmp_pc("j target", 7'h3C, jump_target);
			expect_ctrl(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
		end
		give_credits(1);
		issue_one(make_j(OP_JAL, 26'h0012345), 7'd61, ok);
		if (ok) begin
			cmp_pc("jal target", 7'h45, jump_target);
			cmp_reg("jal dest", 5'd31, dest);
			cmp_data("jal reg_dst", DATA_W'(REG_DST_RA), DATA_W'(reg_dst));
			expect_ctrl(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
		end
		give_credits(1);
		finish_test();
	endtask

	task automatic credit_backpressure();
		int issues;
		begin_test("credit_backpressure");
		issues      = 0;
		instr_valid = 1'b1;
		instr       = make_i(OP_ADDI, 5'd1, 5'd2, 16'd1);
		pc          = 7'd40;
		// no returns, so four slots then a stall
		repeat (10) begin
			@(negedge clock);
			if (issue_valid)
				issues++;
		end
		cmp_data("issues without return", DATA_W'(4), DATA_W'(issues));
		cmp_ctrl("instr_ready_o when out of credit", 1'b0, instr_ready);
		give_credits(1);
		issues = 0;
		repeat (6) begin
			@(negedge clock);
			if (issue_valid)
				issues++;
		end
		cmp_data("issues after one return", DATA_W'(1), DATA_W'(issues));
		cmp_ctrl("instr_ready_o after one return", 1'b0, instr_ready);
		@(posedge clock);
		#DRIVE_DLY;
		instr_valid = 1'b0;
		// drain the held one and hand every slot back
		give_credits(5);
		finish_test();
	endtask

	task automatic halt_and_restart();
		bit ok;
		int issues;
		begin_test("halt_and_restart");
		issues = 0;
		send_instr(make_j(OP_HALT, 26'h0), 7'd50, ok);
		// offer another word, which must not be taken
		instr_valid = 1'b1;
		instr       = make_i(OP_ADDI, 5'd1, 5'd1, 16'd7);
		repeat (6) begin
			@(negedge clock);
			if (issue_valid)
				issues++;
		end
		cmp_data("issues after halt", '0, DATA_W'(issues));
		cmp_ctrl("halted_o", 1'b1, halted);
		cmp_ctrl("instr_ready_o while halted", 1'b0, instr_ready);
		@(posedge clock);
		#DRIVE_DLY;
		instr_valid = 1'b0;
		rst_req     = 1'b1;
		@(posedge clock);
		#DRIVE_DLY;
		rst_req = 1'b0;
		wait_until(SIG_RUN, "reset release", ok);
		cmp_ctrl("instr_ready_o after reset", 1'b1, instr_ready);
		cmp_ctrl("halted_o after reset", 1'b0, halted);
		cmp_ctrl("issue_valid_o after reset", 1'b0, issue_valid);
		@(posedge clock);
		#DRIVE_DLY;
		issue_one(make_i(OP_ORI, 5'd0, 5'd6, 16'h00FF), 7'd0, ok);
		if (ok)
			cmp_data("imm_ext after reset", 32'h0000_00FF, imm_ext);
		give_credits(1);
		finish_test();
	endtask

	initial begin
		bit ok;
		rst_req       = 1'b0;
		instr_valid   = 1'b0;
		instr         = '0;
		pc            = '0;
		credit_return = 1'b0;
		bank_we       = 1'b0;
		wr_addr       = '0;
		wr_data       = '0;
		alu_result    = '0;
		fwd_a         = 1'b0;
		fwd_b         = 1'b0;
		dbg_sel       = 1'b0;
		dbg_addr      = '0;
		lfsr_q        = 16'd65254;
		err_cnt       = 0;
		tests_run     = 0;
		tests_failed  = 0;
		cur_test      = "power_up";
		for (int r = 0; r < (1<<REG_W); r++)
			reg_model[r] = '0;
		wait_until(SIG_RUN, "reset release", ok);
		@(posedge clock);
		#DRIVE_DLY;
		reg_bank_readback();
		rtype_decode();
		itype_decode();
		branch_jump();
		credit_backpressure();
		halt_and_restart();
		$display("summary: %0d tests run, %0d with errors, %0d check errors",
			tests_run, tests_failed, err_cnt);
		if (err_cnt == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

/* compile.f */
logic/decode_pkg.sv
logic/reg_bank.sv
logic/instr_decoder.sv
logic/branch_resolve.sv
logic/credit_counter.sv
logic/issue_fsm.sv
logic/decode_top.sv
tb/tb_clock_gen.sv
tb/decode_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the decode stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f compile.f --top-module decode_tb \
	--Mdir obj_dir -o decode_sim

./obj_dir/decode_sim > sim.log 2>&1
cat sim.log

if grep -qF "tests failed" sim.log; then
	echo "simulation reported failures"
	exit 1
fi
exit 0
